/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_alu_exec
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^TB PASSED$$' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+include
src/alu_pkg.sv
src/exec_ctrl.sv
src/reg_file.sv
src/alu_core.sv
src/alu_exec_top.sv
tb/tb_alu_exec.sv

/* include/alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// datapath word width
`define ALU_DATA_W   32

// register file geometry
`define ALU_NUM_REGS 8
`define ALU_REG_AW   3

// opcode field width
`define ALU_OP_W     4

`endif

/* src/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module alu_core import alu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  issue,
    input  op_t   op,
    input  word_t a,
    input  word_t b,
    output word_t result,
    output logic  zero,
    output logic  overflow
);

    localparam int MSB = `ALU_DATA_W - 1;

    word_t sum;
    word_t diff;
    word_t alu_res;
    logic  alu_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        alu_res = '0;
        alu_ovf = 1'b0;
        case (op)
            OP_ADD: begin
                alu_res = sum;
                // same-sign operands, result sign flipped
                alu_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            end
            OP_SUB: begin
                alu_res = diff;
                // opposite-sign operands, result sign differs from a
                alu_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
            end
            OP_AND: begin
                alu_res = a & b;
            end
            OP_OR: begin
                alu_res = a | b;
            end
            OP_XOR: begin
                alu_res = a ^ b;
            end
            OP_NOT: begin
                alu_res = ~a;
            end
            OP_EQ: begin
                alu_res = word_t'(a == b);
            end
            OP_LT: begin
                alu_res = word_t'($signed(a) < $signed(b));
            end
            OP_GT: begin
                alu_res = word_t'($signed(a) > $signed(b));
            end
            default: begin
                // illegal opcodes read as zero
                alu_res = '0;
            end
        endcase
    end

    // outputs hold between issues
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result   <= '0;
            zero     <= 1'b0;
            overflow <= 1'b0;
        end else if (issue) begin
            result   <= alu_res;
            zero     <= (alu_res == '0);
            overflow <= alu_ovf;
        end
    end

    // only arithmetic may report overflow
    a_ovf_arith_only: assert property (
        @(posedge clk) disable iff (rst)
        issue && !(op == OP_ADD || op == OP_SUB) |=> !overflow
    ) else $error("overflow set after a non-arithmetic op");

endmodule

`default_nettype wire

/* src/alu_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top import alu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  logic      load_en,
    input  reg_addr_t load_addr,
    input  word_t     load_data,
    output logic      result_valid,
    output word_t     result,
    output logic      zero,
    output logic      overflow,
    output logic      illegal
);

    op_t       op;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      issue;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    exec_ctrl i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .op          (op),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .issue       (issue),
        .wb_valid    (result_valid),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .illegal     (illegal)
    );

    // registered alu result doubles as writeback data
    reg_file i_regs (
        .clk       (clk),
        .rst       (rst),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (result),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    alu_core i_alu (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .op       (op),
        .a        (rs1_data),
        .b        (rs2_data),
        .result   (result),
        .zero     (zero),
        .overflow (overflow)
    );

endmodule

`default_nettype wire

/* src/alu_pkg.sv */
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_DATA_W-1:0] word_t;
    typedef logic [`ALU_REG_AW-1:0] reg_addr_t;
    typedef logic [`ALU_OP_W-1:0]   op_t;

    // op | rd | rs1 | rs2
    localparam int INSTR_W = `ALU_OP_W + 3 * `ALU_REG_AW;
    typedef logic [INSTR_W-1:0] instr_t;

    localparam int RS2_LSB = 0;
    localparam int RS1_LSB = RS2_LSB + `ALU_REG_AW;
    localparam int RD_LSB  = RS1_LSB + `ALU_REG_AW;
    localparam int OP_LSB  = RD_LSB + `ALU_REG_AW;

    localparam op_t OP_ADD = 4'd0;
    localparam op_t OP_SUB = 4'd1;
    localparam op_t OP_AND = 4'd2;
    localparam op_t OP_OR  = 4'd3;
    localparam op_t OP_XOR = 4'd4;
    localparam op_t OP_NOT = 4'd5;
    localparam op_t OP_EQ  = 4'd6;
    localparam op_t OP_LT  = 4'd7;
    // highest legal opcode
    localparam op_t OP_GT  = 4'd8;

endpackage

`default_nettype wire

/* src/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module exec_ctrl import alu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  instr_t    instr,
    output op_t       op,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      issue,
    output logic      wb_valid,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output logic      illegal
);

    reg_addr_t rd;
    logic      op_illegal;

    // field decode
    assign op       = instr[OP_LSB  +: `ALU_OP_W];
    assign rd       = instr[RD_LSB  +: `ALU_REG_AW];
    assign rs1_addr = instr[RS1_LSB +: `ALU_REG_AW];
    assign rs2_addr = instr[RS2_LSB +: `ALU_REG_AW];

    assign issue      = instr_valid;
    assign op_illegal = (op > OP_GT);

    // valid pulses for one cycle while illegal holds like the flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= instr_valid;
            if (instr_valid) begin
                illegal <= op_illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            wb_addr <= rd;
        end
    end

    assign wb_en = wb_valid && !illegal;

    // writeback only for a legal instruction issued one cycle earlier
    a_illegal_no_wb: assert property (
        @(posedge clk) disable iff (rst)
        wb_en |-> $past(instr_valid && !op_illegal)
    ) else $error("illegal opcode produced a writeback");

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module reg_file import alu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      load_en,
    input  reg_addr_t load_addr,
    input  word_t     load_data
);

    word_t regs [`ALU_NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ALU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end else if (load_en) begin
            regs[load_addr] <= load_data;
        end
    end

    // write-through, writeback ahead of load
    assign rs1_data = (wb_en && wb_addr == rs1_addr)     ? wb_data   :
                      (load_en && load_addr == rs1_addr) ? load_data :
                      regs[rs1_addr];

    assign rs2_data = (wb_en && wb_addr == rs2_addr)     ? wb_data   :
                      (load_en && load_addr == rs2_addr) ? load_data :
                      regs[rs2_addr];

    // preloads must stay clear of writeback cycles
    a_no_load_on_wb: assert property (
        @(posedge clk) disable iff (rst)
        !(wb_en && load_en)
    ) else $error("load strobe collides with writeback");

endmodule

`default_nettype wire

/* tb/tb_alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module tb_alu_exec import alu_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 16;
    localparam int N_RAND       = 16;

    // rough cycle budget per test, in run order
    localparam int TEST_CYCLES = (`ALU_NUM_REGS + 2)
                               + (N_RAND * 8 + 12)
                               + (8 * 4 + N_RAND * 8)
                               + (7 * 2 * 4)
                               + 24
                               + (7 * 5);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    localparam word_t MAX_POS = {1'b0, {(`ALU_DATA_W - 1){1'b1}}};
    localparam word_t MIN_NEG = {1'b1, {(`ALU_DATA_W - 1){1'b0}}};

    logic      clk = 1'b0;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    logic      load_en;
    reg_addr_t load_addr;
    word_t     load_data;
    logic      result_valid;
    word_t     result;
    logic      zero;
    logic      overflow;
    logic      illegal;

    // expected register contents
    word_t shadow [`ALU_NUM_REGS];
    int    n_errors;
    int    n_checks;
    logic  wb_pending;

    alu_exec_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result       (result),
        .zero         (zero),
        .overflow     (overflow),
        .illegal      (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(string what, word_t got, word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail @ %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic instr_t encode_instr(op_t op, reg_addr_t rd, reg_addr_t rs1,
                                            reg_addr_t rs2);
        instr_t w;
        w = '0;
        w[OP_LSB  +: `ALU_OP_W]   = op;
        w[RD_LSB  +: `ALU_REG_AW] = rd;
        w[RS1_LSB +: `ALU_REG_AW] = rs1;
        w[RS2_LSB +: `ALU_REG_AW] = rs2;
        return w;
    endfunction

    // arithmetic done wide and signed, then truncated
    function automatic word_t ref_result(op_t op, word_t a, word_t b);
        longint sa;
        longint sb;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            OP_ADD:  return word_t'(sa + sb);
            OP_SUB:  return word_t'(sa - sb);
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOT:  return ~a;
            OP_EQ:   return (a == b) ? word_t'(1) : word_t'(0);
            OP_LT:   return (sa < sb) ? word_t'(1) : word_t'(0);
            OP_GT:   return (sa > sb) ? word_t'(1) : word_t'(0);
            default: return '0;
        endcase
    endfunction

    // overflow when the exact result leaves the signed range
    function automatic logic ref_overflow(op_t op, word_t a, word_t b);
        longint wide;
        longint max_val;
        longint min_val;
        max_val = (longint'(1) <<< (`ALU_DATA_W - 1)) - 1;
        min_val = -(longint'(1) <<< (`ALU_DATA_W - 1));
        if (op == OP_ADD) begin
            wide = longint'($signed(a)) + longint'($signed(b));
        end else if (op == OP_SUB) begin
            wide = longint'($signed(a)) - longint'($signed(b));
        end else begin
            return 1'b0;
        end
        return (wide > max_val) || (wide < min_val);
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(`ALU_NUM_REGS - 1, 0));
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        wb_pending = 1'b0;
    endtask

    task automatic issue_instr(op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        word_t a;
        word_t b;
        word_t exp_res;
        logic  exp_ovf;
        logic  exp_ill;
        string tag;
        a       = shadow[rs1];
        b       = shadow[rs2];
        exp_ill = (op > OP_GT);
        exp_res = exp_ill ? '0 : ref_result(op, a, b);
        exp_ovf = exp_ill ? 1'b0 : ref_overflow(op, a, b);
        tag     = $sformatf("op %0d rd %0d rs1 %0d rs2 %0d", op, rd, rs1, rs2);
        instr       = encode_instr(op, rd, rs1, rs2);
        instr_valid = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        instr_valid = 1'b0;
        check_value({tag, " result_valid"}, word_t'(result_valid), word_t'(1'b1));
        check_value({tag, " result"}, result, exp_res);
        check_value({tag, " zero"}, word_t'(zero), word_t'(exp_res == '0));
        check_value({tag, " overflow"}, word_t'(overflow), word_t'(exp_ovf));
        check_value({tag, " illegal"}, word_t'(illegal), word_t'(exp_ill));
        if (!exp_ill) begin
            shadow[rd] = exp_res;
        end
        wb_pending = !exp_ill;
    endtask

    // a load may not share an edge with a writeback
    task automatic load_reg(reg_addr_t addr, word_t data);
        if (wb_pending) begin
            idle_cycle();
        end
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        @(posedge clk);
        #DRIVE_DLY;
        load_en     = 1'b0;
        shadow[addr] = data;
        wb_pending  = 1'b0;
    endtask

    // load and read of the same register in one cycle
    task automatic load_with_read(reg_addr_t addr, word_t data, reg_addr_t rd);
        if (wb_pending) begin
            idle_cycle();
        end
        load_en      = 1'b1;
        load_addr    = addr;
        load_data    = data;
        shadow[addr] = data;
        issue_instr(OP_OR, rd, addr, addr);
        load_en = 1'b0;
    endtask

    task automatic run_pair(op_t op, word_t a, word_t b);
        load_reg(reg_addr_t'(1), a);
        load_reg(reg_addr_t'(2), b);
        issue_instr(op, reg_addr_t'(3), reg_addr_t'(1), reg_addr_t'(2));
    endtask

    task automatic check_reset_state();
        check_value("reset result_valid", word_t'(result_valid), '0);
        check_value("reset result", result, '0);
        check_value("reset zero", word_t'(zero), '0);
        check_value("reset overflow", word_t'(overflow), '0);
        check_value("reset illegal", word_t'(illegal), '0);
        for (int r = 0; r < `ALU_NUM_REGS; r++) begin
            issue_instr(OP_OR, reg_addr_t'(r), reg_addr_t'(r), reg_addr_t'(r));
        end
        idle_cycle();
        check_value("result_valid after pulse", word_t'(result_valid), '0);
    endtask

    task automatic logic_ops();
        reg_addr_t ra;
        reg_addr_t rb;
        word_t     v;
        for (int n = 0; n < N_RAND; n++) begin
            ra = rand_reg();
            rb = ra + reg_addr_t'($urandom_range(`ALU_NUM_REGS - 1, 1));
            load_reg(ra, $urandom());
            load_reg(rb, $urandom());
            issue_instr(OP_AND, rand_reg(), ra, rb);
            issue_instr(OP_OR, rand_reg(), ra, rb);
            issue_instr(OP_XOR, rand_reg(), ra, rb);
            issue_instr(OP_NOT, rand_reg(), ra, rb);
            issue_instr(OP_EQ, rand_reg(), ra, rb);
        end
        // complementary operands
        v = $urandom();
        load_reg(reg_addr_t'(4), v);
        load_reg(reg_addr_t'(5), ~v);
        issue_instr(OP_AND, reg_addr_t'(6), reg_addr_t'(4), reg_addr_t'(5));
        issue_instr(OP_EQ, reg_addr_t'(7), reg_addr_t'(4), reg_addr_t'(4));
        issue_instr(OP_EQ, reg_addr_t'(7), reg_addr_t'(4), reg_addr_t'(5));
        issue_instr(OP_XOR, reg_addr_t'(7), reg_addr_t'(4), reg_addr_t'(5));
    endtask

    task automatic arith_boundaries();
        run_pair(OP_ADD, MAX_POS, word_t'(1));
        run_pair(OP_ADD, MIN_NEG, '1);
        run_pair(OP_ADD, MAX_POS, MIN_NEG);
        run_pair(OP_SUB, MIN_NEG, word_t'(1));
        run_pair(OP_SUB, MAX_POS, '1);
        run_pair(OP_SUB, '1, MAX_POS);
        run_pair(OP_SUB, '0, MIN_NEG);
        run_pair(OP_SUB, word_t'(5), word_t'(-3));
        for (int n = 0; n < N_RAND; n++) begin
            run_pair(OP_ADD, $urandom(), $urandom());
            run_pair(OP_SUB, $urandom(), $urandom());
        end
    endtask

    task automatic compare_both(word_t a, word_t b);
        run_pair(OP_LT, a, b);
        run_pair(OP_GT, a, b);
    endtask

    task automatic signed_compares();
        compare_both(word_t'(-5), word_t'(3));
        compare_both(word_t'(3), word_t'(-5));
        compare_both(word_t'(-5), word_t'(-5));
        compare_both(word_t'(-1), word_t'(-2));
        compare_both(word_t'(-2), word_t'(-1));
        compare_both(MIN_NEG, MAX_POS);
        compare_both(MAX_POS, MIN_NEG);
    endtask

    task automatic dependent_chain();
        reg_addr_t prev;
        reg_addr_t nxt;
        load_reg(reg_addr_t'(0), $urandom());
        load_reg(reg_addr_t'(1), $urandom());
        prev = reg_addr_t'(1);
        for (int n = 0; n < 12; n++) begin
            nxt = rand_reg();
            issue_instr(op_t'($urandom_range(int'(OP_GT), 0)), nxt, prev, rand_reg());
            prev = nxt;
        end
        load_with_read(reg_addr_t'(3), $urandom(), reg_addr_t'(4));
        load_with_read(reg_addr_t'(6), '0, reg_addr_t'(6));
    endtask

    task automatic illegal_opcodes();
        reg_addr_t dest;
        for (int k = int'(OP_GT) + 1; k < (1 << `ALU_OP_W); k++) begin
            dest = rand_reg();
            load_reg(dest, $urandom() | word_t'(1));
            issue_instr(op_t'(k), dest, rand_reg(), rand_reg());
            // destination must still hold the loaded value
            issue_instr(OP_OR, dest, dest, dest);
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hcab3));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        n_errors    = 0;
        n_checks    = 0;
        wb_pending  = 1'b0;
        for (int i = 0; i < `ALU_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        check_reset_state();
        logic_ops();
        arith_boundaries();
        signed_compares();
        dependent_chain();
        illegal_opcodes();
        idle_cycle();

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
